//--- all.f
+incdir+hw
hw/mext_pkg.sv
hw/exe_issue.sv
hw/muldiv.sv
hw/mul_writeback.sv
hw/mext_top.sv
sim/mext_assertions.sv
sim/tb_mext.sv

//--- hw/exe_issue.sv
// Issue stage that decodes M-extension funct3 and registers the request for the multiply unit
`include "mext_settings.svh"

module exe_issue import mext_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    stall,
    input  logic                    flush,
    input  logic                    instr_valid,
    input  logic [2:0]              instr_funct3,
    input  logic [`REG_AW-1:0]      instr_rd,
    input  logic [`XLEN-1:0]        rs1_data,
    input  logic [`XLEN-1:0]        rs2_data,
    output type_exe2mul_s           exe2mul
);

    type_alu_m_ops_e    op_next;
    type_exe2mul_s      exe2mul_next;

    // funct3 to operation code
    always_comb begin
        op_next = ALU_M_OPS_NONE;
        if (instr_valid) begin
            case (instr_funct3)
                3'd0: begin
                    op_next = ALU_M_OPS_MUL;
                end
                3'd1: begin
                    op_next = ALU_M_OPS_MULH;
                end
                3'd2: begin
                    op_next = ALU_M_OPS_MULHSU;
                end
                3'd3: begin
                    op_next = ALU_M_OPS_MULHU;
                end
                3'd4: begin
                    op_next = ALU_M_OPS_DIV;
                end
                3'd5: begin
                    op_next = ALU_M_OPS_DIVU;
                end
                3'd6: begin
                    op_next = ALU_M_OPS_REM;
                end
                default: begin
                    op_next = ALU_M_OPS_REMU;
                end
            endcase
        end
    end

    always_comb begin
        exe2mul_next.alu_m_ops     = op_next;
        exe2mul_next.alu_operand_1 = rs1_data;
        exe2mul_next.alu_operand_2 = rs2_data;
        exe2mul_next.alu_m_rd      = instr_rd;
    end

    // Flush wins over stall
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            exe2mul <= '0;
        end else if (!stall) begin
            exe2mul <= exe2mul_next;
        end
    end

endmodule

//--- hw/mext_pkg.sv
// Operation codes and stage-to-stage structs shared by the multiply/divide path
`include "mext_settings.svh"

package mext_pkg;

    // RV32M operations in funct3 order, zero means no request
    typedef enum logic [3:0] {
        ALU_M_OPS_NONE   = 4'd0,
        ALU_M_OPS_MUL    = 4'd1,
        ALU_M_OPS_MULH   = 4'd2,
        ALU_M_OPS_MULHSU = 4'd3,
        ALU_M_OPS_MULHU  = 4'd4,
        ALU_M_OPS_DIV    = 4'd5,
        ALU_M_OPS_DIVU   = 4'd6,
        ALU_M_OPS_REM    = 4'd7,
        ALU_M_OPS_REMU   = 4'd8
    } type_alu_m_ops_e;

    // Issue stage to arithmetic unit
    typedef struct packed {
        type_alu_m_ops_e        alu_m_ops;
        logic [`XLEN-1:0]       alu_operand_1;
        logic [`XLEN-1:0]       alu_operand_2;
        logic [`REG_AW-1:0]     alu_m_rd;
    } type_exe2mul_s;

    // Arithmetic unit to writeback
    typedef struct packed {
        logic                   alu_m_req;
        logic [`XLEN-1:0]       alu_m_result;
        logic [`REG_AW-1:0]     alu_m_rd;
    } type_mul2lsu_s;

    // Register file write strobe
    typedef struct packed {
        logic                   wb_valid;
        logic [`REG_AW-1:0]     wb_rd;
        logic [`XLEN-1:0]       wb_data;
    } type_mul_wb_s;

endpackage

//--- hw/mext_settings.svh
// Data and register-index widths for the M-extension path, included by the package and RTL
`ifndef MEXT_SETTINGS_SVH
`define MEXT_SETTINGS_SVH

// Machine word width
`define XLEN 32

// Register file index width
`define REG_AW 5

`endif

//--- hw/mext_top.sv
// Top of the multiply/divide path chaining issue, arithmetic and writeback stages
`include "mext_settings.svh"

module mext_top import mext_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    stall,
    input  logic                    flush,
    input  logic                    instr_valid,
    input  logic [2:0]              instr_funct3,
    input  logic [`REG_AW-1:0]      instr_rd,
    input  logic [`XLEN-1:0]        rs1_data,
    input  logic [`XLEN-1:0]        rs2_data,
    output logic                    wb_valid,
    output logic [`REG_AW-1:0]      wb_rd,
    output logic [`XLEN-1:0]        wb_data
);

    type_exe2mul_s      exe2mul;
    type_mul2lsu_s      mul2lsu;
    type_mul_wb_s       wb;

    exe_issue u_exe_issue (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall        (stall),
        .flush        (flush),
        .instr_valid  (instr_valid),
        .instr_funct3 (instr_funct3),
        .instr_rd     (instr_rd),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .exe2mul      (exe2mul)
    );

    muldiv u_muldiv (
        .clk          (clk),
        .rst_n        (rst_n),
        .exe2mul      (exe2mul),
        .stall        (stall),
        .flush        (flush),
        .mul2lsu      (mul2lsu)
    );

    mul_writeback u_mul_writeback (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall        (stall),
        .mul2lsu      (mul2lsu),
        .wb           (wb)
    );

    // Register file side
    assign wb_valid = wb.wb_valid;
    assign wb_rd    = wb.wb_rd;
    assign wb_data  = wb.wb_data;

endmodule

//--- hw/mul_writeback.sv
// Writeback stage that turns finished multiply/divide results into register-file write strobes
`include "mext_settings.svh"

module mul_writeback import mext_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    stall,
    input  type_mul2lsu_s           mul2lsu,
    output type_mul_wb_s            wb
);

    logic               rd_nonzero;
    type_mul_wb_s       wb_next;

    // x0 is hardwired to zero
    assign rd_nonzero = (mul2lsu.alu_m_rd != '0);

    always_comb begin
        wb_next.wb_valid = mul2lsu.alu_m_req && rd_nonzero;
        wb_next.wb_rd    = mul2lsu.alu_m_rd;
        wb_next.wb_data  = mul2lsu.alu_m_result;
    end

    // Already committed, so flush does not reach here
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb <= '0;
        end else if (!stall) begin
            wb <= wb_next;
        end
    end

endmodule

//--- hw/muldiv.sv
// Single-cycle RV32M multiply/divide unit with a registered result, driven by the issue stage
`include "mext_settings.svh"

module muldiv import mext_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  type_exe2mul_s           exe2mul,
    input  logic                    stall,
    input  logic                    flush,
    output type_mul2lsu_s           mul2lsu
);

    localparam logic [`XLEN-1:0] MOST_NEG = {1'b1, {(`XLEN-1){1'b0}}};
    localparam logic [`XLEN-1:0] ALL_ONES = '1;

    type_alu_m_ops_e            alu_m_ops;
    logic [`XLEN-1:0]           op_a;
    logic [`XLEN-1:0]           op_b;

    logic [2*`XLEN-1:0]         prod_uu;
    logic [2*`XLEN-1:0]         prod_ss;
    logic [2*`XLEN-1:0]         prod_su;

    logic                       div_zero;
    logic                       div_ovf;
    logic [`XLEN-1:0]           div_b;
    logic [`XLEN-1:0]           quot_s;
    logic [`XLEN-1:0]           quot_u;
    logic [`XLEN-1:0]           rem_s;
    logic [`XLEN-1:0]           rem_u;

    logic [`XLEN-1:0]           result_next;
    type_mul2lsu_s              mul2lsu_next;

    assign alu_m_ops = exe2mul.alu_m_ops;
    assign op_a      = exe2mul.alu_operand_1;
    assign op_b      = exe2mul.alu_operand_2;

    // Full-width products, high half selected later
    always_comb begin
        prod_uu = {{`XLEN{1'b0}}, op_a} * {{`XLEN{1'b0}}, op_b};
        prod_ss = $signed(op_a) * $signed(op_b);
        prod_su = $signed(op_a) * $signed({1'b0, op_b});
    end

    assign div_zero = (op_b == '0);
    assign div_ovf  = (op_a == MOST_NEG) && (op_b == ALL_ONES);

    // Keep the divider away from zero, the corner cases are patched below
    assign div_b = div_zero ? {{(`XLEN-1){1'b0}}, 1'b1} : op_b;

    always_comb begin
        quot_u = op_a / div_b;
        rem_u  = op_a % div_b;
        quot_s = $signed(op_a) / $signed(div_b);
        rem_s  = $signed(op_a) % $signed(div_b);
        if (div_zero) begin
            quot_u = ALL_ONES;
            rem_u  = op_a;
            quot_s = ALL_ONES;
            rem_s  = op_a;
        end else if (div_ovf) begin
            quot_s = op_a;
            rem_s  = '0;
        end
    end

    // Result select
    always_comb begin
        case (alu_m_ops)
            ALU_M_OPS_MUL: begin
                result_next = prod_ss[`XLEN-1:0];
            end
            ALU_M_OPS_MULH: begin
                result_next = prod_ss[2*`XLEN-1:`XLEN];
            end
            ALU_M_OPS_MULHSU: begin
                result_next = prod_su[2*`XLEN-1:`XLEN];
            end
            ALU_M_OPS_MULHU: begin
                result_next = prod_uu[2*`XLEN-1:`XLEN];
            end
            ALU_M_OPS_DIV: begin
                result_next = quot_s;
            end
            ALU_M_OPS_DIVU: begin
                result_next = quot_u;
            end
            ALU_M_OPS_REM: begin
                result_next = rem_s;
            end
            ALU_M_OPS_REMU: begin
                result_next = rem_u;
            end
            default: begin
                result_next = '0;
            end
        endcase
    end

    always_comb begin
        mul2lsu_next.alu_m_req    = |alu_m_ops;
        mul2lsu_next.alu_m_result = result_next;
        mul2lsu_next.alu_m_rd     = exe2mul.alu_m_rd;
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            mul2lsu <= '0;
        end else if (!stall) begin
            mul2lsu <= mul2lsu_next;
        end
    end

endmodule

//--- sim/mext_assertions.sv
// Register checks for one pipeline stage, attached from the testbench with bind
`include "mext_settings.svh"

module mext_assertions (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        stall,
    input  logic                        flush,
    input  logic                        valid,
    input  logic [`XLEN+`REG_AW:0]      payload
);

    timeunit 1ns;
    timeprecision 100ps;

    // Synchronous reset empties the stage
    property reset_clears_valid;
        @(posedge clk) !rst_n |=> !valid;
    endproperty

    // Flushed stages come out empty
    property flush_clears_valid;
        @(posedge clk) flush |=> !valid;
    endproperty

    // A stalled edge leaves the whole register untouched
    property stall_holds_payload;
        @(posedge clk) disable iff (!rst_n)
            (stall && !flush) |=> $stable(payload);
    endproperty

    reset_clears_valid_a: assert property (reset_clears_valid)
        else $error("stage still valid after a reset edge");

    flush_clears_valid_a: assert property (flush_clears_valid)
        else $error("stage still valid after a flush edge");

    stall_holds_payload_a: assert property (stall_holds_payload)
        else $error("stage register changed on a stalled edge");

endmodule

//--- sim/tb_mext.sv
// Directed testbench for the multiply/divide path, compiled from all.f with tb_mext as top
`include "mext_settings.svh"

module tb_mext import mext_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [2:0] F3_MUL    = 3'd0;
    localparam logic [2:0] F3_MULH   = 3'd1;
    localparam logic [2:0] F3_MULHSU = 3'd2;
    localparam logic [2:0] F3_MULHU  = 3'd3;
    localparam logic [2:0] F3_DIV    = 3'd4;
    localparam logic [2:0] F3_DIVU   = 3'd5;
    localparam logic [2:0] F3_REM    = 3'd6;
    localparam logic [2:0] F3_REMU   = 3'd7;

    localparam logic [`XLEN-1:0] MOST_NEG = {1'b1, {(`XLEN-1){1'b0}}};
    localparam logic [`XLEN-1:0] MINUS_ONE = '1;

    logic                   clk;
    logic                   rst_n;
    logic                   stall;
    logic                   flush;
    logic                   instr_valid;
    logic [2:0]             instr_funct3;
    logic [`REG_AW-1:0]     instr_rd;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;
    logic                   wb_valid;
    logic [`REG_AW-1:0]     wb_rd;
    logic [`XLEN-1:0]       wb_data;

    // Expected writebacks as {rd, data} in issue order
    logic [`REG_AW+`XLEN-1:0]   expected_q[$];
    bit                         stall_mode;

    mext_top DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall        (stall),
        .flush        (flush),
        .instr_valid  (instr_valid),
        .instr_funct3 (instr_funct3),
        .instr_rd     (instr_rd),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data)
    );

    // Writeback has no flush input, so its flush is tied low
    bind muldiv mext_assertions u_muldiv_checks (
        .clk(clk), .rst_n(rst_n), .stall(stall), .flush(flush),
        .valid(mul2lsu.alu_m_req), .payload(mul2lsu)
    );
    bind mul_writeback mext_assertions u_wb_checks (
        .clk(clk), .rst_n(rst_n), .stall(stall), .flush(1'b0),
        .valid(wb.wb_valid), .payload(wb)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // RV32M result from the ISA rules with division done on magnitudes
    function automatic logic [`XLEN-1:0] model_result(input logic [2:0] f3,
            input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
        logic [2*`XLEN-1:0] a_s;
        logic [2*`XLEN-1:0] a_u;
        logic [2*`XLEN-1:0] b_s;
        logic [2*`XLEN-1:0] b_u;
        logic [2*`XLEN-1:0] prod;
        logic [`XLEN-1:0]   mag_a;
        logic [`XLEN-1:0]   mag_b;
        logic [`XLEN-1:0]   q;
        logic [`XLEN-1:0]   r;
        logic [`XLEN-1:0]   result;
        a_s = {{`XLEN{a[`XLEN-1]}}, a};
        a_u = {{`XLEN{1'b0}}, a};
        b_s = {{`XLEN{b[`XLEN-1]}}, b};
        b_u = {{`XLEN{1'b0}}, b};
        mag_a = a[`XLEN-1] ? -a : a;
        mag_b = b[`XLEN-1] ? -b : b;
        q = (b == '0) ? '0 : mag_a / mag_b;
        r = (b == '0) ? '0 : mag_a % mag_b;
        prod = '0;
        result = '0;
        case (f3)
            F3_MUL: begin
                prod = a_u * b_u;
                result = prod[`XLEN-1:0];
            end
            F3_MULH: begin
                prod = a_s * b_s;
                result = prod[2*`XLEN-1:`XLEN];
            end
            F3_MULHSU: begin
                prod = a_s * b_u;
                result = prod[2*`XLEN-1:`XLEN];
            end
            F3_MULHU: begin
                prod = a_u * b_u;
                result = prod[2*`XLEN-1:`XLEN];
            end
            F3_DIV: begin
                if (b == '0) begin
                    result = '1;
                end else if (a == MOST_NEG && b == MINUS_ONE) begin
                    result = a;
                end else begin
                    result = (a[`XLEN-1] ^ b[`XLEN-1]) ? -q : q;
                end
            end
            F3_DIVU: begin
                result = (b == '0) ? '1 : a / b;
            end
            F3_REM: begin
                if (b == '0) begin
                    result = a;
                end else if (a == MOST_NEG && b == MINUS_ONE) begin
                    result = '0;
                end else begin
                    result = a[`XLEN-1] ? -r : r;
                end
            end
            default: begin
                result = (b == '0) ? a : a % b;
            end
        endcase
        return result;
    endfunction

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [`XLEN-1:0] actual,
            input logic [`XLEN-1:0] expected);
        if (actual !== expected) begin
            stop_with_error($sformatf("Fail at %0d ns: %s is %h, expected %h",
                $time, name, actual, expected));
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Present one instruction and keep it there until an edge without stall
    task automatic send(input logic [2:0] f3, input logic [`REG_AW-1:0] rd,
            input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b, input bit commits);
        int   waited;
        logic held;
        instr_valid  = 1'b1;
        instr_funct3 = f3;
        instr_rd     = rd;
        rs1_data     = a;
        rs2_data     = b;
        if (commits && rd != '0) begin
            expected_q.push_back({rd, model_result(f3, a, b)});
        end
        waited = 0;
        held = 1'b1;
        while (held) begin
            stall = stall_mode ? ($urandom_range(0, 3) == 0) : 1'b0;
            held = stall;
            next_cycle();
            waited++;
            if (waited > 40) begin
                stop_with_error("Instruction was never accepted because stall stayed high");
            end
        end
        instr_valid = 1'b0;
        stall = 1'b0;
    endtask

    task automatic bubble();
        instr_valid = 1'b0;
        stall = stall_mode ? ($urandom_range(0, 1) == 1) : 1'b0;
        next_cycle();
        stall = 1'b0;
    endtask

    task automatic drain_queue();
        int waited;
        instr_valid = 1'b0;
        stall = 1'b0;
        waited = 0;
        while (expected_q.size() != 0) begin
            next_cycle();
            waited++;
            if (waited > 20) begin
                stop_with_error("Timed out waiting for the remaining writebacks");
            end
        end
        // Idle a little so a stray writeback would still show up
        repeat (4) next_cycle();
    endtask

    // Writeback monitor counting a strobe only after an unstalled edge
    initial begin
        logic                       edge_stall;
        logic                       edge_rst;
        logic [`REG_AW+`XLEN-1:0]   expected;
        forever begin
            @(posedge clk);
            edge_stall = stall;
            edge_rst = rst_n;
            @(negedge clk);
            if (edge_rst === 1'b1 && edge_stall === 1'b0 && wb_valid === 1'b1) begin
                if (expected_q.size() == 0) begin
                    stop_with_error($sformatf("Unexpected writeback to x%0d with data %h",
                        wb_rd, wb_data));
                end
                expected = expected_q.pop_front();
                check_value("wb_rd", wb_rd, expected[`REG_AW+`XLEN-1:`XLEN]);
                check_value("wb_data", wb_data, expected[`XLEN-1:0]);
            end
        end
    end

    task automatic test_reset();
        repeat (16) begin
            next_cycle();
            check_value("wb_valid", wb_valid, '0);
        end
        rst_n = 1'b1;
        repeat (4) begin
            next_cycle();
            check_value("wb_valid", wb_valid, '0);
        end
    endtask

    task automatic test_all_ops();
        logic [`XLEN-1:0]   op_a [6];
        logic [`XLEN-1:0]   op_b [6];
        logic [`REG_AW-1:0] rd;
        op_a = '{32'd7, 32'hffff_fff9, 32'd7, 32'hffff_fff9, 32'h1234_5678, 32'hffff_ffff};
        op_b = '{32'd3, 32'd3, 32'hffff_fffd, 32'hffff_fffd, 32'h9abc_def0, 32'hffff_ffff};
        rd = 5'd1;
        for (int f = 0; f < 8; f++) begin
            for (int i = 0; i < 6; i++) begin
                send(3'(f), rd, op_a[i], op_b[i], 1'b1);
                rd = (rd == 5'd31) ? 5'd1 : rd + 5'd1;
            end
        end
        drain_queue();
    endtask

    task automatic test_corner_cases();
        check_value("model DIV by zero", model_result(F3_DIV, 32'd42, '0), '1);
        check_value("model REMU by zero", model_result(F3_REMU, 32'd42, '0), 32'd42);
        check_value("model DIV overflow", model_result(F3_DIV, MOST_NEG, MINUS_ONE), MOST_NEG);
        check_value("model REM overflow", model_result(F3_REM, MOST_NEG, MINUS_ONE), '0);
        send(F3_DIV, 5'd10, 32'd42, '0, 1'b1);
        send(F3_DIVU, 5'd11, 32'd42, '0, 1'b1);
        send(F3_REM, 5'd12, 32'hffff_ffd6, '0, 1'b1);
        send(F3_REMU, 5'd13, 32'd42, '0, 1'b1);
        send(F3_DIV, 5'd14, MOST_NEG, MINUS_ONE, 1'b1);
        send(F3_REM, 5'd15, MOST_NEG, MINUS_ONE, 1'b1);
        drain_queue();
    endtask

    task automatic random_instruction();
        logic [`XLEN-1:0] b;
        if ($urandom_range(0, 4) == 0) begin
            bubble();
        end
        b = ($urandom_range(0, 7) == 0) ? '0 : $urandom;
        send(3'($urandom_range(0, 7)), 5'($urandom_range(0, 31)), $urandom, b, 1'b1);
    endtask

    task automatic test_random_stream();
        for (int i = 0; i < 200; i++) begin
            random_instruction();
        end
        drain_queue();
    endtask

    task automatic test_stall_flush();
        stall_mode = 1'b1;
        for (int i = 0; i < 100; i++) begin
            random_instruction();
        end
        stall_mode = 1'b0;
        drain_queue();

        // At the flush edge B moves into writeback behind A while C and D are dropped
        send(F3_MUL, 5'd1, 32'd3, 32'd4, 1'b1);
        send(F3_DIVU, 5'd2, 32'd100, 32'd7, 1'b1);
        send(F3_REM, 5'd3, 32'hffff_ff9c, 32'd7, 1'b0);
        flush = 1'b1;
        send(F3_MULHU, 5'd4, 32'hdead_beef, 32'hcafe_f00d, 1'b0);
        flush = 1'b0;
        send(F3_MULH, 5'd5, 32'h8000_0001, 32'h7fff_ffff, 1'b1);
        send(F3_DIV, 5'd6, 32'hffff_ff00, 32'd16, 1'b1);
        drain_queue();
    endtask

    initial begin
        void'($urandom(91261));
        rst_n        = 1'b0;
        stall        = 1'b0;
        flush        = 1'b0;
        instr_valid  = 1'b0;
        instr_funct3 = '0;
        instr_rd     = '0;
        rs1_data     = '0;
        rs2_data     = '0;
        stall_mode   = 1'b0;

        test_reset();
        test_all_ops();
        test_corner_cases();
        test_random_stream();
        test_stall_flush();

        if (expected_q.size() == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            stop_with_error("Some expected writebacks never arrived");
        end
    end

endmodule
